//--- verilog/fib_pkg.sv
// fibonacci datapath definitions
// shared types for the sequencer, register file and ALU

package fib_pkg;

	// the write sequence covers exactly this many registers
	localparam int NUM_REGS = 16;

	// register index, wide enough for NUM_REGS entries
	typedef logic [3:0] reg_idx_t;

	// ALU operations used by the sequence
	typedef enum logic [1:0] {
		OP_NOP  = 2'd0, // no write this cycle
		OP_ADD  = 2'd1, // port a + port b
		OP_ADDI = 2'd2  // port a + immediate
	} alu_op_t;

	// everything the sequencer drives into the datapath in one cycle
	typedef struct packed {
		alu_op_t  op;     // operation for the ALU
		logic     clear;  // clear registers and overflow
		logic     wr_en;  // register write enable
		reg_idx_t wr_sel; // destination register
		reg_idx_t rd_a;   // read port a address
		reg_idx_t rd_b;   // read port b address
	} ctrl_t;

	// idle value of the control word
	localparam ctrl_t CTRL_IDLE = '{
		op:     OP_NOP,
		clear:  1'b0,
		wr_en:  1'b0,
		wr_sel: '0,
		rd_a:   '0,
		rd_b:   '0
	};

endpackage

//--- verilog/fib_sequencer.sv
// fibonacci control sequencer
// waits for start, clears the register file, then issues sixteen writes
// that build the table; busy during the run, done until the next start

`timescale 1ns/1ps

module fib_sequencer (
	input  logic            clk,
	input  logic            rst,
	input  logic            start,
	output fib_pkg::ctrl_t  ctrl,
	output logic            busy,
	output logic            done
);

	import fib_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_CLEAR = 2'd1,
		ST_WRITE = 2'd2,
		ST_DONE  = 2'd3
	} state_t;

	localparam reg_idx_t LAST_STEP = reg_idx_t'(NUM_REGS - 1);

	state_t   state;
	state_t   state_next;
	reg_idx_t step;      // register written in ST_WRITE
	reg_idx_t step_next;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			step  <= '0;
		end else begin
			state <= state_next;
			step  <= step_next;
		end
	end

	// next state
	always_comb begin
		state_next = state;
		step_next  = step;
		case (state)
			ST_IDLE: begin
				if (start)
					state_next = ST_CLEAR;
			end
			ST_CLEAR: begin
				state_next = ST_WRITE;
				step_next  = '0;
			end
			ST_WRITE: begin
				if (step == LAST_STEP) begin
					state_next = ST_DONE;
				end else begin
					step_next = step + 4'd1;
				end
			end
			ST_DONE: begin
				if (start) // rerun, previous results get cleared
					state_next = ST_CLEAR;
			end
			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

	// control word, defined in every state
	always_comb begin
		ctrl = CTRL_IDLE;
		case (state)
			ST_CLEAR: begin
				ctrl.clear = 1'b1;
			end
			ST_WRITE: begin
				ctrl.wr_en  = 1'b1;
				ctrl.wr_sel = step;
				if (step < 4'd2) begin
					// seed registers: cleared value plus imm
					ctrl.op   = OP_ADDI;
					ctrl.rd_a = step;
					ctrl.rd_b = step;
				end else begin
					ctrl.op   = OP_ADD;
					ctrl.rd_a = step - 4'd2; // two below
					ctrl.rd_b = step - 4'd1; // one below
				end
			end
			default: begin
				ctrl = CTRL_IDLE; // idle and done issue nothing
			end
		endcase
	end

	assign busy = (state == ST_CLEAR) || (state == ST_WRITE);
	assign done = (state == ST_DONE);

endmodule

//--- verilog/reg_file.sv
// register file for the fibonacci datapath
// NUM_REGS words with synchronous clear, one write port and
// three combinational read ports (two for the ALU, one external)

`timescale 1ns/1ps

module reg_file #(
	parameter int WIDTH = 16
) (
	input  logic                 clk,
	input  logic                 rst,
	input  fib_pkg::ctrl_t       ctrl,
	input  logic [WIDTH-1:0]     wr_data,
	input  fib_pkg::reg_idx_t    rd_addr,
	output logic [WIDTH-1:0]     a_data,
	output logic [WIDTH-1:0]     b_data,
	output logic [WIDTH-1:0]     rd_data
);

	import fib_pkg::*;

	logic [WIDTH-1:0] regs [NUM_REGS];

	// clear wins over a write in the same cycle
	always_ff @(posedge clk) begin
		if (rst || ctrl.clear) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.wr_en) begin
			regs[ctrl.wr_sel] <= wr_data;
		end
	end

	// read ports
	always_comb begin
		a_data  = regs[ctrl.rd_a];  // ALU operand a
		b_data  = regs[ctrl.rd_b];  // ALU operand b
		rd_data = regs[rd_addr];    // external readback
	end

endmodule

//--- verilog/fib_alu.sv
// adder ALU for the fibonacci datapath
// picks port b or the immediate as second operand, adds with carry out
// and keeps a sticky overflow flag for the current run

`timescale 1ns/1ps

module fib_alu #(
	parameter int WIDTH = 16
) (
	input  logic              clk,
	input  logic              rst,
	input  fib_pkg::ctrl_t    ctrl,
	input  logic [WIDTH-1:0]  a_data,
	input  logic [WIDTH-1:0]  b_data,
	input  logic [WIDTH-1:0]  imm,
	output logic [WIDTH-1:0]  sum,
	output logic              overflow
);

	import fib_pkg::*;

	logic [WIDTH-1:0] operand_b;
	logic [WIDTH:0]   sum_full; // one extra bit for the carry
	logic             add_cycle;

	always_comb begin
		case (ctrl.op)
			OP_ADDI: operand_b = imm;
			default: operand_b = b_data;
		endcase
	end

	assign sum_full  = {1'b0, a_data} + {1'b0, operand_b};
	assign sum       = sum_full[WIDTH-1:0];
	assign add_cycle = (ctrl.op == OP_ADD) || (ctrl.op == OP_ADDI);

	// sticky until the next clear
	always_ff @(posedge clk) begin
		if (rst || ctrl.clear) begin
			overflow <= 1'b0;
		end else if (add_cycle && sum_full[WIDTH]) begin
			overflow <= 1'b1;
		end
	end

endmodule

//--- verilog/fib_top.sv
// fibonacci table generator
// sequencer drives the register file and adder ALU so that register k
// ends up holding imm * F(k+1), with an external read port

`timescale 1ns/1ps

module fib_top #(
	parameter int WIDTH = 16
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  logic [WIDTH-1:0]   imm,
	input  fib_pkg::reg_idx_t  rd_addr,
	output logic [WIDTH-1:0]   rd_data,
	output logic               busy,
	output logic               done,
	output logic               overflow
);

	import fib_pkg::*;

	ctrl_t            ctrl;   // per-cycle control from the sequencer
	logic [WIDTH-1:0] a_data;
	logic [WIDTH-1:0] b_data;
	logic [WIDTH-1:0] sum;    // ALU result into the write port

	fib_sequencer seq_i (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.ctrl  (ctrl),
		.busy  (busy),
		.done  (done)
	);

	reg_file #(
		.WIDTH (WIDTH)
	) regs_i (
		.clk     (clk),
		.rst     (rst),
		.ctrl    (ctrl),
		.wr_data (sum),
		.rd_addr (rd_addr),
		.a_data  (a_data),
		.b_data  (b_data),
		.rd_data (rd_data)
	);

	fib_alu #(
		.WIDTH (WIDTH)
	) alu_i (
		.clk      (clk),
		.rst      (rst),
		.ctrl     (ctrl),
		.a_data   (a_data),
		.b_data   (b_data),
		.imm      (imm),
		.sum      (sum),
		.overflow (overflow)
	);

endmodule

//--- test/fib_properties.sv
// sequencer checks for the fibonacci datapath
// concurrent assertions on the control word and the busy and done levels

`timescale 1ns/1ps

module fib_properties (
	input logic           clk,
	input logic           rst,
	input logic           start,
	input fib_pkg::ctrl_t ctrl,
	input logic           busy,
	input logic           done
);

	// a cycle either clears or writes, never both
	clear_write_excl: assert property (
		@(posedge clk) disable iff (rst)
		!(ctrl.clear && ctrl.wr_en)
	) else $error("clear and wr_en high in the same cycle");

	busy_done_excl: assert property (
		@(posedge clk) disable iff (rst)
		!(busy && done)
	) else $error("busy and done high together");

	// done is a level that only a new start takes down
	done_hold: assert property (
		@(posedge clk) disable iff (rst)
		(done && !start) |=> done
	) else $error("done dropped without a start");

	clear_one_cycle: assert property (
		@(posedge clk) disable iff (rst)
		ctrl.clear |=> !ctrl.clear
	) else $error("clear held for more than one cycle");

endmodule

//--- test/fib_tb.sv
// testbench for the fibonacci table generator
// runs a table of immediates through fib_top and checks the done latency,
// busy, the sticky overflow flag and every register against imm * F(k+1)

`timescale 1ns/1ps

module fib_tb;

	import fib_pkg::*;

	localparam int WIDTH          = 16;
	localparam int LATENCY        = 17; // edges after the start edge until done is seen
	localparam int RESTART_AT     = 5;  // run cycle that gets the ignored start pulse
	localparam int NUM_ROWS       = 9;
	localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + 100;

	typedef struct packed {
		logic [WIDTH-1:0] imm;
		logic [WIDTH-1:0] rand_mask; // nonzero: imm comes from $urandom under this mask
		logic             restart;   // pulse start again while busy
		logic             exp_ovf;
	} row_t;

	logic             clk;
	logic             rst;
	logic             start;
	logic [WIDTH-1:0] imm;
	reg_idx_t         rd_addr;
	logic [WIDTH-1:0] rd_data;
	logic             busy;
	logic             done;
	logic             overflow;

	row_t rows [NUM_ROWS];
	int   cycle_count;
	int   row_errors;   // mismatches in the test that is running
	int   error_count;
	int   tests_run;
	int   tests_failed;

	fib_top #(
		.WIDTH (WIDTH)
	) dut_i (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.imm      (imm),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.busy     (busy),
		.done     (done),
		.overflow (overflow)
	);

	bind fib_sequencer fib_properties props_i (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.ctrl  (ctrl),
		.busy  (busy),
		.done  (done)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("test failed");
			$finish;
		end
	end

	// F(n) with F(1) = F(2) = 1
	function automatic longint unsigned fib_num(input int n);
		longint unsigned f_prev;
		longint unsigned f_cur;
		longint unsigned f_next;
		f_prev = 0;
		f_cur  = 1;
		for (int i = 1; i < n; i++) begin
			f_next = f_prev + f_cur;
			f_prev = f_cur;
			f_cur  = f_next;
		end
		return f_cur;
	endfunction

	function automatic logic [WIDTH-1:0] expected_word(input logic [WIDTH-1:0] imm_val,
			input int k);
		longint unsigned product;
		product = 64'(imm_val) * fib_num(k + 1);
		return product[WIDTH-1:0]; // mod 2^WIDTH
	endfunction

	// set when any exact value of the recurrence reaches 2^WIDTH
	function automatic logic expected_overflow(input logic [WIDTH-1:0] imm_val);
		longint unsigned limit;
		logic            ovf;
		limit = 64'd1 << WIDTH;
		ovf   = 1'b0;
		for (int k = 0; k < NUM_REGS; k++) begin
			if (64'(imm_val) * fib_num(k + 1) >= limit)
				ovf = 1'b1;
		end
		return ovf;
	endfunction

	task automatic check_word(input string name, input logic [WIDTH-1:0] got,
			input logic [WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
			row_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, got, exp);
			row_errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
			row_errors++;
		end
	endtask

	task automatic finish_test(input string label);
		tests_run++;
		if (row_errors == 0) begin
			$display("%s: ok", label);
		end else begin
			$display("%s: %0d mismatches", label, row_errors);
			tests_failed++;
		end
		error_count += row_errors;
		row_errors = 0;
	endtask

	task automatic read_reg(input int k, input logic [WIDTH-1:0] exp);
		@(posedge clk);
		#1;
		rd_addr = reg_idx_t'(k);
		@(negedge clk);
		check_word($sformatf("rd_data[%0d]", k), rd_data, exp);
	endtask

	task automatic fill_table();
		rows[0] = '{imm: 16'd1,     rand_mask: 16'h0000, restart: 1'b0, exp_ovf: 1'b0};
		rows[1] = '{imm: 16'd2,     rand_mask: 16'h0000, restart: 1'b1, exp_ovf: 1'b0};
		rows[2] = '{imm: 16'd0,     rand_mask: 16'h0000, restart: 1'b0, exp_ovf: 1'b0};
		rows[3] = '{imm: 16'd3,     rand_mask: 16'h0000, restart: 1'b0, exp_ovf: 1'b0};
		rows[4] = '{imm: 16'd66,    rand_mask: 16'h0000, restart: 1'b0, exp_ovf: 1'b0};
		rows[5] = '{imm: 16'd67,    rand_mask: 16'h0000, restart: 1'b1, exp_ovf: 1'b1};
		rows[6] = '{imm: 16'hffff,  rand_mask: 16'h0000, restart: 1'b0, exp_ovf: 1'b1};
		rows[7] = '{imm: 16'd0,     rand_mask: 16'hffff, restart: 1'b0, exp_ovf: 1'b0};
		rows[8] = '{imm: 16'd0,     rand_mask: 16'h007f, restart: 1'b1, exp_ovf: 1'b0};
	endtask

	task automatic run_row(input int r);
		logic [WIDTH-1:0] imm_val;
		logic             exp_ovf;
		logic             restart;
		logic [31:0]      rnd;
		logic             seen_done;
		int               lat;
		imm_val = rows[r].imm;
		exp_ovf = rows[r].exp_ovf;
		restart = rows[r].restart;
		if (rows[r].rand_mask != '0) begin
			rnd     = $urandom;
			imm_val = rnd[WIDTH-1:0] & rows[r].rand_mask;
			exp_ovf = expected_overflow(imm_val);
		end
		@(posedge clk);
		#1;
		imm     = imm_val;
		rd_addr = reg_idx_t'(NUM_REGS - 1); // last register written, watches the clear
		start   = 1'b1;
		@(posedge clk); // start sampled here
		#1;
		start     = 1'b0;
		lat       = 0;
		seen_done = 1'b0;
		@(negedge clk);
		check_flag("busy", busy, 1'b1);
		check_flag("done", done, 1'b0);
		while (!seen_done) begin
			@(posedge clk);
			lat++;
			#1;
			start = restart && (lat == RESTART_AT); // must be ignored
			@(negedge clk);
			if (lat == 1) begin
				check_word("rd_data[15] after clear", rd_data, '0);
				check_flag("overflow after clear", overflow, 1'b0);
			end
			if (done)
				seen_done = 1'b1;
			else
				check_flag("busy", busy, 1'b1);
		end
		check_count("done latency", lat, LATENCY);
		check_flag("busy", busy, 1'b0);
		check_flag("overflow", overflow, exp_ovf);
		for (int k = 0; k < NUM_REGS; k++) begin
			read_reg(k, expected_word(imm_val, k));
		end
		check_flag("done held", done, 1'b1);
		finish_test($sformatf("row %0d imm=%h restart=%b", r, imm_val, restart));
	endtask

	initial begin
		int unsigned seed_val;
		clk          = 1'b0;
		rst          = 1'b1;
		start        = 1'b0;
		imm          = '0;
		rd_addr      = '0;
		cycle_count  = 0;
		row_errors   = 0;
		error_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		seed_val     = $urandom(85);
		fill_table();

		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		check_flag("busy", busy, 1'b0);
		check_flag("done", done, 1'b0);
		check_flag("overflow", overflow, 1'b0);
		for (int k = 0; k < NUM_REGS; k++) begin
			read_reg(k, '0);
		end
		finish_test("reset");

		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end

		$display("runs %0d, runs with errors %0d, mismatches %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- filelist.f
verilog/fib_pkg.sv
verilog/fib_sequencer.sv
verilog/reg_file.sv
verilog/fib_alu.sv
verilog/fib_top.sv
test/fib_properties.sv
test/fib_tb.sv

//--- Makefile
# Verilator simulation of the fibonacci datapath

TOP = fib_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f \
		--Mdir obj_dir -o $(TOP)_sim
	./obj_dir/$(TOP)_sim 2>&1 | tee sim.log
	@if grep -q "test failed" sim.log || ! grep -q "test passed" sim.log; then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
